/* common/demo_soc_config.svh */
`ifndef DEMO_SOC_CONFIG_SVH
`define DEMO_SOC_CONFIG_SVH

// Bus widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 32

// Memory map as base and size pairs
`define RAM_BASE   32'h0010_0000
`define RAM_SIZE   (16 * 1024)

`define GPIO_BASE  32'h8000_0000
`define TIMER_BASE 32'h8000_2000

// GPIO and timer share one window size
`define DEV_SIZE   (4 * 1024)

`define GPI_WIDTH  8
`define GPO_WIDTH  16

`endif

/* common/demo_soc_pkg.sv */
`default_nettype none

`include "demo_soc_config.svh"

package demo_soc_pkg;

  typedef logic [`ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`DATA_WIDTH-1:0]   data_t;
  typedef logic [`DATA_WIDTH/8-1:0] be_t;
  typedef logic [`GPI_WIDTH-1:0]    gpi_t;
  typedef logic [`GPO_WIDTH-1:0]    gpo_t;
  typedef logic [63:0]              tick_t;

  // Host to device
  typedef struct packed {
    addr_t addr;
    logic  we;
    be_t   be;
    data_t wdata;
  } bus_req_t;

  // Device to host, one cycle after the grant
  typedef struct packed {
    logic  rvalid;
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    dev_ram,
    dev_gpio,
    dev_timer,
    dev_none
  } dev_sel_e;

  // Replace only the enabled bytes of a word
  function automatic data_t merge_be(input data_t old_d, input data_t new_d, input be_t be);
    data_t res;
    res = old_d;
    for (int i = 0; i < $bits(be_t); i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_d[8*i +: 8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

/* bus/bus_ctrl.sv */
`default_nettype none

`include "demo_soc_config.svh"

module bus_ctrl (
  input  wire logic                   clk_sys_i,
  input  wire logic                   rst_sys_ni,

  input  wire logic                   req_i,
  input  wire demo_soc_pkg::bus_req_t bus_req_i,
  output logic                        gnt_o,

  output demo_soc_pkg::bus_req_t      dev_req_o,
  output logic                        ram_req_o,
  output logic                        gpio_req_o,
  output logic                        timer_req_o,

  input  wire demo_soc_pkg::bus_rsp_t ram_rsp_i,
  input  wire demo_soc_pkg::bus_rsp_t gpio_rsp_i,
  input  wire demo_soc_pkg::bus_rsp_t timer_rsp_i,
  output demo_soc_pkg::bus_rsp_t      rsp_o
);
  import demo_soc_pkg::*;

  localparam addr_t ram_base   = `RAM_BASE;
  localparam addr_t ram_mask   = ~(addr_t'(`RAM_SIZE) - addr_t'(1));
  localparam addr_t gpio_base  = `GPIO_BASE;
  localparam addr_t timer_base = `TIMER_BASE;
  localparam addr_t dev_mask   = ~(addr_t'(`DEV_SIZE) - addr_t'(1));

  dev_sel_e dev_sel;
  dev_sel_e sel_q;  // Target of the access in flight
  logic     req_q;

  always_comb begin
    dev_sel = dev_none;
    if ((bus_req_i.addr & ram_mask) == ram_base) begin
      dev_sel = dev_ram;
    end else if ((bus_req_i.addr & dev_mask) == gpio_base) begin
      dev_sel = dev_gpio;
    end else if ((bus_req_i.addr & dev_mask) == timer_base) begin
      dev_sel = dev_timer;
    end
  end

  // All devices accept every cycle
  assign gnt_o = req_i;

  assign dev_req_o   = bus_req_i;
  assign ram_req_o   = gnt_o & (dev_sel == dev_ram);
  assign gpio_req_o  = gnt_o & (dev_sel == dev_gpio);
  assign timer_req_o = gnt_o & (dev_sel == dev_timer);

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      req_q <= 1'b0;
      sel_q <= dev_none;
    end else begin
      req_q <= req_i & gnt_o;
      sel_q <= dev_sel;
    end
  end

  always_comb begin
    case (sel_q)
      dev_ram:   rsp_o = ram_rsp_i;
      dev_gpio:  rsp_o = gpio_rsp_i;
      dev_timer: rsp_o = timer_rsp_i;
      default: begin
        // Unmapped address
        rsp_o.rvalid = req_q;
        rsp_o.rdata  = '0;
        rsp_o.err    = req_q;
      end
    endcase
  end

  a_one_select: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    $onehot0({ram_req_o, gpio_req_o, timer_req_o}));

  // Every device answers in the next cycle
  a_rsp_after_gnt: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    req_i && gnt_o |=> rsp_o.rvalid);

endmodule

`default_nettype wire

/* hw/sram.sv */
`default_nettype none

module sram #(
  parameter int Depth = 4096
) (
  input  wire logic                   clk_sys_i,
  input  wire logic                   rst_sys_ni,

  input  wire logic                   req_i,
  input  wire demo_soc_pkg::bus_req_t dev_req_i,
  output demo_soc_pkg::bus_rsp_t      rsp_o
);
  import demo_soc_pkg::*;

  localparam int addr_bits = $clog2(Depth);

  data_t                mem [Depth];
  logic [addr_bits-1:0] word_addr;
  logic                 rvalid_q;
  data_t                rdata_q;

  // Byte offset bits are dropped
  assign word_addr = dev_req_i.addr[addr_bits+1:2];

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      if (dev_req_i.we) begin
        mem[word_addr] <= merge_be(mem[word_addr], dev_req_i.wdata, dev_req_i.be);
        rdata_q        <= '0;
      end else begin
        rdata_q <= mem[word_addr];
      end
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rsp_o = '{rvalid: rvalid_q, rdata: rdata_q, err: 1'b0};

endmodule

`default_nettype wire

/* hw/gpio_regs.sv */
`default_nettype none

`include "demo_soc_config.svh"

module gpio_regs (
  input  wire logic                   clk_sys_i,
  input  wire logic                   rst_sys_ni,

  input  wire logic                   req_i,
  input  wire demo_soc_pkg::bus_req_t dev_req_i,
  input  wire demo_soc_pkg::gpi_t     gp_i_i,

  output demo_soc_pkg::bus_rsp_t      rsp_o,
  output demo_soc_pkg::gpo_t          gp_o
);
  import demo_soc_pkg::*;

  localparam int                  off_bits = $clog2(`DEV_SIZE);
  localparam logic [off_bits-1:0] off_gpo  = 'h0;
  localparam logic [off_bits-1:0] off_gpi  = 'h4;

  logic [off_bits-1:0] offset;
  gpi_t                gpi_meta_q;
  gpi_t                gpi_sync_q;
  gpo_t                gpo_q;
  logic                rvalid_q;
  data_t               rdata_q;

  assign offset = dev_req_i.addr[off_bits-1:0];

  // Two-flop synchronizer on the inputs
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
    end else begin
      gpi_meta_q <= gp_i_i;
      gpi_sync_q <= gpi_meta_q;
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpo_q    <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
      if (req_i && dev_req_i.we && offset == off_gpo) begin
        gpo_q <= gpo_t'(merge_be(data_t'(gpo_q), dev_req_i.wdata, dev_req_i.be));
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      if (dev_req_i.we) begin
        rdata_q <= '0;
      end else begin
        case (offset)
          off_gpo: rdata_q <= data_t'(gpo_q);
          off_gpi: rdata_q <= data_t'(gpi_sync_q);  // Zero-extended
          default: rdata_q <= '0;
        endcase
      end
    end
  end

  assign gp_o  = gpo_q;
  assign rsp_o = '{rvalid: rvalid_q, rdata: rdata_q, err: 1'b0};

  a_rvalid_after_req: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    rsp_o.rvalid |-> $past(req_i));

endmodule

`default_nettype wire

/* timer/timer_regs.sv */
`default_nettype none

`include "demo_soc_config.svh"

module timer_regs (
  input  wire logic                   clk_sys_i,
  input  wire logic                   rst_sys_ni,

  input  wire logic                   req_i,
  input  wire demo_soc_pkg::bus_req_t dev_req_i,

  output demo_soc_pkg::bus_rsp_t      rsp_o,
  output logic                        timer_irq_o
);
  import demo_soc_pkg::*;

  localparam int                  off_bits    = $clog2(`DEV_SIZE);
  localparam logic [off_bits-1:0] off_time_lo = 'h0;
  localparam logic [off_bits-1:0] off_time_hi = 'h4;
  localparam logic [off_bits-1:0] off_cmp_lo  = 'h8;
  localparam logic [off_bits-1:0] off_cmp_hi  = 'hC;

  logic [off_bits-1:0] offset;
  logic                wr_en;
  tick_t               mtime_q;
  tick_t               mtimecmp_q;
  logic                cmp_written_q;
  logic                irq_q;
  logic                rvalid_q;
  data_t               rdata_q;

  assign offset = dev_req_i.addr[off_bits-1:0];
  assign wr_en  = req_i & dev_req_i.we;

  // A bus write to the counter takes priority over the increment
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q <= '0;
    end else if (wr_en && offset == off_time_lo) begin
      mtime_q <= {mtime_q[63:32], merge_be(mtime_q[31:0], dev_req_i.wdata, dev_req_i.be)};
    end else if (wr_en && offset == off_time_hi) begin
      mtime_q <= {merge_be(mtime_q[63:32], dev_req_i.wdata, dev_req_i.be), mtime_q[31:0]};
    end else begin
      mtime_q <= mtime_q + tick_t'(1);
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtimecmp_q    <= '1;  // Never fires out of reset
      cmp_written_q <= 1'b0;
      irq_q         <= 1'b0;
      rvalid_q      <= 1'b0;
    end else begin
      rvalid_q <= req_i;
      irq_q    <= (mtime_q >= mtimecmp_q);
      if (wr_en && offset == off_cmp_lo) begin
        mtimecmp_q[31:0] <= merge_be(mtimecmp_q[31:0], dev_req_i.wdata, dev_req_i.be);
        cmp_written_q    <= 1'b1;
      end else if (wr_en && offset == off_cmp_hi) begin
        mtimecmp_q[63:32] <= merge_be(mtimecmp_q[63:32], dev_req_i.wdata, dev_req_i.be);
        cmp_written_q     <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      if (dev_req_i.we) begin
        rdata_q <= '0;
      end else begin
        case (offset)
          off_time_lo: rdata_q <= mtime_q[31:0];
          off_time_hi: rdata_q <= mtime_q[63:32];
          off_cmp_lo:  rdata_q <= mtimecmp_q[31:0];
          off_cmp_hi:  rdata_q <= mtimecmp_q[63:32];
          default:     rdata_q <= '0;
        endcase
      end
    end
  end

  assign timer_irq_o = irq_q;
  assign rsp_o       = '{rvalid: rvalid_q, rdata: rdata_q, err: 1'b0};

  a_irq_quiet_until_cmp: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    !cmp_written_q |-> !timer_irq_o);

endmodule

`default_nettype wire

/* hw/demo_soc_top.sv */
`default_nettype none

`include "demo_soc_config.svh"

module demo_soc_top (
  input  wire logic                   clk_sys_i,
  input  wire logic                   rst_sys_ni,

  // External bus host
  input  wire logic                   req_i,
  input  wire demo_soc_pkg::bus_req_t bus_req_i,
  output logic                        gnt_o,
  output demo_soc_pkg::bus_rsp_t      rsp_o,

  input  wire demo_soc_pkg::gpi_t     gp_i_i,
  output demo_soc_pkg::gpo_t          gp_o,
  output logic                        timer_irq_o
);
  import demo_soc_pkg::*;

  bus_req_t dev_req;
  logic     ram_req;
  logic     gpio_req;
  logic     timer_req;
  bus_rsp_t ram_rsp;
  bus_rsp_t gpio_rsp;
  bus_rsp_t timer_rsp;

  bus_ctrl u_bus_ctrl (
    .clk_sys_i   (clk_sys_i),
    .rst_sys_ni  (rst_sys_ni),
    .req_i       (req_i),
    .bus_req_i   (bus_req_i),
    .gnt_o       (gnt_o),
    .dev_req_o   (dev_req),
    .ram_req_o   (ram_req),
    .gpio_req_o  (gpio_req),
    .timer_req_o (timer_req),
    .ram_rsp_i   (ram_rsp),
    .gpio_rsp_i  (gpio_rsp),
    .timer_rsp_i (timer_rsp),
    .rsp_o       (rsp_o)
  );

  sram #(
    .Depth (`RAM_SIZE / 4)  // One entry per 32-bit word
  ) u_sram (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .req_i      (ram_req),
    .dev_req_i  (dev_req),
    .rsp_o      (ram_rsp)
  );

  gpio_regs u_gpio_regs (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .req_i      (gpio_req),
    .dev_req_i  (dev_req),
    .gp_i_i     (gp_i_i),
    .rsp_o      (gpio_rsp),
    .gp_o       (gp_o)
  );

  timer_regs u_timer_regs (
    .clk_sys_i   (clk_sys_i),
    .rst_sys_ni  (rst_sys_ni),
    .req_i       (timer_req),
    .dev_req_i   (dev_req),
    .rsp_o       (timer_rsp),
    .timer_irq_o (timer_irq_o)
  );

endmodule

`default_nettype wire

/* bench/tb_tests.svh */
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

int    test_start_errors;
data_t ram_model [8];  // Expected RAM contents
gpo_t  gpo_model;

function automatic data_t replace_bytes(input data_t old_word, input data_t new_word,
                                        input be_t be);
  data_t mask;
  mask = '0;
  for (int b = 0; b < 4; b++) begin
    mask[8*b +: 8] = {8{be[b]}};
  end
  return (old_word & ~mask) | (new_word & mask);
endfunction

function automatic addr_t ram_word_addr(input int i);
  return `RAM_BASE + addr_t'(i * 2044);  // Spread over the whole RAM
endfunction

task automatic start_test();
  test_start_errors = errors;
endtask

task automatic end_test(input string name);
  tests_run++;
  if (errors > test_start_errors) begin
    tests_failed++;
    $display("Test %s: %0d errors", name, errors - test_start_errors);
  end else begin
    $display("Test %s: ok", name);
  end
endtask

task automatic test_reset();
  bus_rsp_t r;
  start_test();
  check_value("rvalid after reset", data_t'(rsp.rvalid), '0);
  check_value("gp_o after reset", data_t'(gpo), '0);
  check_value("timer_irq_o after reset", data_t'(timer_irq), '0);
  bus_access(`TIMER_BASE + 32'hC, 1'b0, 4'hf, '0, r);
  check_value("compare high after reset", r.rdata, 32'hffff_ffff);
  end_test("reset");
endtask

task automatic test_ram();
  be_t      lanes [8];
  data_t    wdata;
  bus_rsp_t r;
  start_test();
  lanes = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b0101, 4'b1010};
  for (int i = 0; i < 8; i++) begin
    ram_model[i] = $random(seed);
    bus_access(ram_word_addr(i), 1'b1, 4'hf, ram_model[i], r);
  end
  for (int i = 0; i < 8; i++) begin
    bus_access(ram_word_addr(i), 1'b0, 4'hf, '0, r);
    check_value($sformatf("RAM word %0d", i), r.rdata, ram_model[i]);
  end
  // Partial byte writes
  for (int i = 0; i < 8; i++) begin
    wdata = $random(seed);
    bus_access(ram_word_addr(i), 1'b1, lanes[i], wdata, r);
    ram_model[i] = replace_bytes(ram_model[i], wdata, lanes[i]);
  end
  for (int i = 0; i < 8; i++) begin
    bus_access(ram_word_addr(i), 1'b0, 4'hf, '0, r);
    check_value($sformatf("RAM word %0d after byte write", i), r.rdata, ram_model[i]);
  end
  end_test("ram");
endtask

task automatic test_gpio();
  data_t    wdata;
  gpi_t     drive_val;
  bus_rsp_t r;
  start_test();
  gpo_model = '0;
  wdata = $random(seed);
  bus_access(`GPIO_BASE, 1'b1, 4'b0010, wdata, r);
  gpo_model = gpo_t'(replace_bytes(data_t'(gpo_model), wdata, 4'b0010));
  check_value("gp_o after upper byte write", data_t'(gpo), data_t'(gpo_model));
  wdata = $random(seed);
  bus_access(`GPIO_BASE, 1'b1, 4'b0101, wdata, r);  // Byte 2 lies past the register
  gpo_model = gpo_t'(replace_bytes(data_t'(gpo_model), wdata, 4'b0101));
  check_value("gp_o after low byte write", data_t'(gpo), data_t'(gpo_model));
  bus_access(`GPIO_BASE, 1'b0, 4'hf, '0, r);
  check_value("GPIO output readback", r.rdata, data_t'(gpo_model));
  drive_val = gpi_t'($random(seed));
  gp_i = drive_val;
  wait_cycles(4);
  bus_access(`GPIO_BASE + 32'h4, 1'b0, 4'hf, '0, r);
  check_value("GPIO input read", r.rdata, data_t'(drive_val));
  end_test("gpio");
endtask

task automatic test_back_to_back();
  addr_t    addrs [6];
  data_t    exp_data [6];
  logic     exp_err [6];
  bus_rsp_t r;
  start_test();
  for (int i = 0; i < 6; i++) begin
    case (i % 3)
      0: begin
        addrs[i]    = ram_word_addr(i);
        exp_data[i] = ram_model[i];
        exp_err[i]  = 1'b0;
      end
      1: begin
        addrs[i]    = `GPIO_BASE;
        exp_data[i] = data_t'(gpo_model);
        exp_err[i]  = 1'b0;
      end
      default: begin
        addrs[i]    = 32'h4000_0000 + addr_t'(i * 4);  // In no window
        exp_data[i] = '0;
        exp_err[i]  = 1'b1;
      end
    endcase
  end
  // Response to request i-1 is sampled while request i is issued
  for (int i = 0; i <= 6; i++) begin
    if (i > 0) begin
      r = rsp;
      check_value($sformatf("rvalid of read %0d", i - 1), data_t'(r.rvalid), 32'd1);
      check_value($sformatf("rdata of read %0d", i - 1), r.rdata, exp_data[i-1]);
      check_value($sformatf("err of read %0d", i - 1), data_t'(r.err), data_t'(exp_err[i-1]));
    end
    if (i < 6) begin
      drive_req(addrs[i], 1'b0, 4'hf, '0);
      #1;
      check_grant(addrs[i]);
    end else begin
      idle_bus();
    end
    wait_cycles(1);
  end
  end_test("back_to_back");
endtask

task automatic test_timer();
  localparam int lead = 20;
  data_t    t0;
  data_t    t1;
  int       waited;
  bus_rsp_t r;
  start_test();
  bus_access(`TIMER_BASE, 1'b0, 4'hf, '0, r);
  t0 = r.rdata;
  wait_cycles(9);
  bus_access(`TIMER_BASE, 1'b0, 4'hf, '0, r);
  t1 = r.rdata;
  check_value("counter advance over 10 cycles", t1 - t0, 32'd10);

  // Counter high word is still zero this early
  bus_access(`TIMER_BASE + 32'hC, 1'b1, 4'hf, '0, r);
  bus_access(`TIMER_BASE, 1'b0, 4'hf, '0, r);
  t0 = r.rdata;
  bus_access(`TIMER_BASE + 32'h8, 1'b1, 4'hf, t0 + data_t'(lead), r);
  waited = 0;
  while (timer_irq !== 1'b1 && waited < 4 * lead) begin
    wait_cycles(1);
    waited++;
  end
  assert (timer_irq === 1'b1) else begin
    $display("At %0t the timer interrupt did not rise within %0d cycles", $time, waited);
    errors++;
  end
  check_value("cycles until interrupt", data_t'(waited), data_t'(lead - 1));

  bus_access(`TIMER_BASE + 32'hC, 1'b1, 4'hf, 32'hffff_ffff, r);
  wait_cycles(1);
  check_value("timer_irq_o after compare clear", data_t'(timer_irq), '0);
  bus_access(`TIMER_BASE + 32'h8, 1'b1, 4'hf, 32'hffff_ffff, r);
  bus_access(`TIMER_BASE + 32'h8, 1'b0, 4'hf, '0, r);
  check_value("compare low readback", r.rdata, 32'hffff_ffff);
  check_value("timer_irq_o with all-ones compare", data_t'(timer_irq), '0);
  end_test("timer");
endtask

`endif

/* bench/tb_demo_soc.sv */
`default_nettype none

`include "demo_soc_config.svh"

module tb_demo_soc;
  timeunit 1ns;
  timeprecision 1ps;
  import demo_soc_pkg::*;

  localparam int max_cycles = 3000;

  logic     clk_sys;
  logic     rst_sys_n;
  logic     req;
  bus_req_t bus_req;
  gpi_t     gp_i;
  logic     gnt;
  bus_rsp_t rsp;
  gpo_t     gpo;
  logic     timer_irq;

  int errors;
  int tests_run;
  int tests_failed;
  int cycles;
  int seed;

  demo_soc_top DUT (
    .clk_sys_i   (clk_sys),
    .rst_sys_ni  (rst_sys_n),
    .req_i       (req),
    .bus_req_i   (bus_req),
    .gnt_o       (gnt),
    .rsp_o       (rsp),
    .gp_i_i      (gp_i),
    .gp_o        (gpo),
    .timer_irq_o (timer_irq)
  );

  initial begin
    clk_sys = 1'b0;
    forever #4 clk_sys = ~clk_sys;
  end

  always @(posedge clk_sys) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  task automatic drive_req(input addr_t addr, input logic we, input be_t be, input data_t wdata);
    req     = 1'b1;
    bus_req = '{addr: addr, we: we, be: be, wdata: wdata};
  endtask

  task automatic idle_bus();
    req     = 1'b0;
    bus_req = '0;
  endtask

  // Ends 1 ns after the n-th rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_sys);
    #1;
  endtask

  task automatic check_grant(input addr_t addr);
    assert (gnt === 1'b1) else begin
      $display("At %0t the request to %h got no grant", $time, addr);
      errors++;
    end
  endtask

  task automatic check_value(input string what, input data_t got, input data_t exp);
    assert (got === exp) else begin
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Grant checked in the request cycle and the response one cycle later
  task automatic bus_access(input addr_t addr, input logic we, input be_t be,
                            input data_t wdata, output bus_rsp_t r);
    drive_req(addr, we, be, wdata);
    #1;
    check_grant(addr);
    wait_cycles(1);
    idle_bus();
    r = rsp;
    assert (r.rvalid === 1'b1) else begin
      $display("At %0t the access to %h got no response", $time, addr);
      errors++;
    end
  endtask

  `include "tb_tests.svh"

  initial begin
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycles       = 0;
    seed         = 32'h7b6b;
    rst_sys_n    = 1'b0;
    gp_i         = '0;
    idle_bus();
    repeat (5) @(posedge clk_sys);
    #1;
    rst_sys_n = 1'b1;

    test_reset();
    test_ram();
    test_gpio();
    test_back_to_back();
    test_timer();

    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+common
+incdir+bench
common/demo_soc_pkg.sv
bus/bus_ctrl.sv
hw/sram.sv
hw/gpio_regs.sv
timer/timer_regs.sv
hw/demo_soc_top.sv
bench/tb_demo_soc.sv

/* Makefile */
SRCS := $(wildcard common/* bus/* hw/* timer/* bench/*)

all: run

obj_dir/Vtb_demo_soc: flist.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_demo_soc -f flist.f

run: obj_dir/Vtb_demo_soc
	./obj_dir/Vtb_demo_soc | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
